// ==== rtl/fibPkg.sv ====
package fibPkg;

    //////////////////////////////////////////////////
    // datapath sizes
    //////////////////////////////////////////////////

    // term, register and bus width
    localparam int DATA_WIDTH     = 16;
    // three term registers plus the count
    localparam int REG_COUNT      = 4;
    localparam int REG_ADDR_WIDTH = 2;
    // request count, 1 to 31 terms
    localparam int COUNT_WIDTH    = 5;

    //////////////////////////////////////////////////
    // register indices
    //////////////////////////////////////////////////

    // rotating term registers, start positions
    localparam logic [REG_ADDR_WIDTH-1:0] TERM_REG0 = 2'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] TERM_REG1 = 2'd1;
    localparam logic [REG_ADDR_WIDTH-1:0] TERM_REG2 = 2'd2;
    // remaining-count register
    localparam logic [REG_ADDR_WIDTH-1:0] COUNT_REG = 2'd3;

    // alu operation
    typedef enum logic {
        ALU_ADD,
        ALU_DEC
    } aluOpT;

    // register file write source
    typedef enum logic {
        WRITE_ALU,
        WRITE_SEED
    } writeSrcT;

endpackage

// ==== rtl/fibControl.sv ====
`timescale 1ns/1ps

module fibControl (
    input  logic                              clk,
    input  logic                              arstN,
    // request port
    input  logic                              reqValid,
    input  logic [fibPkg::COUNT_WIDTH-1:0]    reqCount,
    output logic                              reqReady,
    // term port handshake
    input  logic                              termReady,
    output logic                              termValid,
    output logic                              termLast,
    // register file control
    output logic [fibPkg::REG_ADDR_WIDTH-1:0] readAddrA,
    output logic [fibPkg::REG_ADDR_WIDTH-1:0] readAddrB,
    output logic [fibPkg::REG_ADDR_WIDTH-1:0] writeAddr,
    output logic                              writeEn,
    output fibPkg::writeSrcT                  writeSrc,
    output logic [fibPkg::DATA_WIDTH-1:0]     seedData,
    // alu and flags
    output fibPkg::aluOpT                     aluOp,
    output logic                              flagClear,
    output logic                              carryLoad,
    output logic                              zeroLoad,
    input  logic                              zeroFlag
);
    import fibPkg::*;

    typedef enum logic [2:0] {IDLE, LOAD, SEED0, SEED1, DEC, EMIT, ADD} stateT;

    stateT                     state;
    stateT                     stateNext;
    // rotating term pointers
    logic [REG_ADDR_WIDTH-1:0] oldestIdx;
    logic [REG_ADDR_WIDTH-1:0] middleIdx;
    logic [REG_ADDR_WIDTH-1:0] newestIdx;
    // count captured at the request transfer
    logic [COUNT_WIDTH-1:0]    countQ;
    logic                      reqFire;
    logic                      termFire;

    assign reqFire  = reqValid && reqReady;
    assign termFire = termValid && termReady;

    //////////////////////////////////////////////////
    // state sequence
    //////////////////////////////////////////////////

    always_comb begin
        stateNext = state;
        case (state)
            IDLE:  if (reqFire) stateNext = LOAD;
            LOAD:  stateNext = SEED0;
            SEED0: stateNext = SEED1;
            SEED1: stateNext = DEC;
            DEC:   stateNext = EMIT;
            // hold here under back-pressure
            EMIT: begin
                if (termFire) begin
                    stateNext = termLast ? IDLE : ADD;
                end
            end
            ADD:     stateNext = DEC;
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= IDLE;
            newestIdx <= TERM_REG0;
            middleIdx <= TERM_REG1;
            oldestIdx <= TERM_REG2;
        end else begin
            state <= stateNext;
            if (state == LOAD) begin
                // F(0) newest, F(-1)=1 behind it
                newestIdx <= TERM_REG0;
                middleIdx <= TERM_REG1;
                oldestIdx <= TERM_REG2;
            end else if (state == ADD) begin
                // oldest slot now holds the new sum
                oldestIdx <= middleIdx;
                middleIdx <= newestIdx;
                newestIdx <= oldestIdx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reqFire) begin
            countQ <= reqCount;
        end
    end

    //////////////////////////////////////////////////
    // datapath control
    //////////////////////////////////////////////////

    always_comb begin
        reqReady  = 1'b0;
        termValid = 1'b0;
        termLast  = 1'b0;
        readAddrA = newestIdx;
        readAddrB = middleIdx;
        writeAddr = COUNT_REG;
        writeEn   = 1'b0;
        writeSrc  = WRITE_ALU;
        seedData  = '0;
        aluOp     = ALU_ADD;
        flagClear = 1'b0;
        carryLoad = 1'b0;
        zeroLoad  = 1'b0;
        case (state)
            IDLE: reqReady = 1'b1;
            LOAD: begin
                writeEn   = 1'b1;
                writeSrc  = WRITE_SEED;
                seedData  = DATA_WIDTH'(countQ);
                flagClear = 1'b1;
            end
            SEED0: begin
                writeAddr = TERM_REG0;
                writeEn   = 1'b1;
                writeSrc  = WRITE_SEED;
            end
            SEED1: begin
                writeAddr = TERM_REG1;
                writeEn   = 1'b1;
                writeSrc  = WRITE_SEED;
                seedData  = DATA_WIDTH'(1);
            end
            // count minus one, zero marks the final term
            DEC: begin
                readAddrA = COUNT_REG;
                writeEn   = 1'b1;
                aluOp     = ALU_DEC;
                zeroLoad  = 1'b1;
            end
            EMIT: begin
                readAddrB = COUNT_REG;
                termValid = 1'b1;
                termLast  = zeroFlag;
            end
            ADD: begin
                writeAddr = oldestIdx;
                writeEn   = 1'b1;
                carryLoad = 1'b1;
            end
            default: ;
        endcase
    end

    // zero count would never raise termLast
    assert property (@(posedge clk) disable iff (!arstN) reqFire |-> reqCount != '0)
        else $error("request accepted with zero count");

    // stalled term keeps valid and last marker
    assert property (@(posedge clk) disable iff (!arstN)
        termValid && !termReady |=> termValid && $stable(termLast))
        else $error("term dropped under back-pressure");

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                              clk,
    input  logic                              arstN,
    // read ports
    input  logic [fibPkg::REG_ADDR_WIDTH-1:0] readAddrA,
    input  logic [fibPkg::REG_ADDR_WIDTH-1:0] readAddrB,
    // write port
    input  logic [fibPkg::REG_ADDR_WIDTH-1:0] writeAddr,
    input  logic                              writeEn,
    input  fibPkg::writeSrcT                  writeSrc,
    input  logic [fibPkg::DATA_WIDTH-1:0]     seedData,
    input  logic [fibPkg::DATA_WIDTH-1:0]     result,
    // operands to the alu
    output logic [fibPkg::DATA_WIDTH-1:0]     operandA,
    output logic [fibPkg::DATA_WIDTH-1:0]     operandB
);
    import fibPkg::*;

    // three terms and the count
    logic [DATA_WIDTH-1:0] regs [REG_COUNT];
    logic [DATA_WIDTH-1:0] writeData;

    // write source mux picks the control seed or the alu result
    assign writeData = (writeSrc == WRITE_SEED) ? seedData : result;

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // asynchronous reads
    assign operandA = regs[readAddrA];
    assign operandB = regs[readAddrB];

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  fibPkg::aluOpT                 aluOp,
    input  logic [fibPkg::DATA_WIDTH-1:0] operandA,
    input  logic [fibPkg::DATA_WIDTH-1:0] operandB,
    output logic [fibPkg::DATA_WIDTH-1:0] result,
    output logic                          carry,
    output logic                          zero
);
    import fibPkg::*;

    // one extra bit for carry or borrow
    logic [DATA_WIDTH:0] wide;

    //////////////////////////////////////////////////
    // operations
    //////////////////////////////////////////////////

    always_comb begin
        case (aluOp)
            // top bit set when 0 - 1 borrows
            ALU_DEC: wide = {1'b0, operandA} - 1'b1;
            // true sum, top bit is the carry out
            default: wide = {1'b0, operandA} + {1'b0, operandB};
        endcase
    end

    // wrapped result
    assign result = wide[DATA_WIDTH-1:0];
    assign carry  = wide[DATA_WIDTH];
    // zero on the wrapped value
    assign zero   = (result == '0);

endmodule

// ==== rtl/flagRegister.sv ====
`timescale 1ns/1ps

module flagRegister (
    input  logic clk,
    input  logic arstN,
    input  logic flagClear,
    input  logic carryLoad,
    input  logic zeroLoad,
    // from the alu
    input  logic carry,
    input  logic zero,
    output logic carrySticky,
    output logic zeroFlag
);

    // clear wins over both loads
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            carrySticky <= 1'b0;
            zeroFlag    <= 1'b0;
        end else if (flagClear) begin
            carrySticky <= 1'b0;
            zeroFlag    <= 1'b0;
        end else begin
            // sticky, only new carries get ORed in
            if (carryLoad) begin
                carrySticky <= carrySticky | carry;
            end
            // last zero result
            if (zeroLoad) begin
                zeroFlag <= zero;
            end
        end
    end

endmodule

// ==== rtl/fibEngine.sv ====
`timescale 1ns/1ps

module fibEngine (
    input  logic                           clk,
    input  logic                           arstN,
    // request port
    input  logic                           reqValid,
    input  logic [fibPkg::COUNT_WIDTH-1:0] reqCount,
    output logic                           reqReady,
    // term port
    output logic                           termValid,
    output logic [fibPkg::DATA_WIDTH-1:0]  termData,
    output logic                           termLast,
    output logic                           termOverflow,
    input  logic                           termReady
);
    import fibPkg::*;

    // register selects and write path
    logic [REG_ADDR_WIDTH-1:0] readAddrA;
    logic [REG_ADDR_WIDTH-1:0] readAddrB;
    logic [REG_ADDR_WIDTH-1:0] writeAddr;
    logic                      writeEn;
    writeSrcT                  writeSrc;
    logic [DATA_WIDTH-1:0]     seedData;
    // alu buses
    aluOpT                     aluOp;
    logic [DATA_WIDTH-1:0]     operandA;
    logic [DATA_WIDTH-1:0]     operandB;
    logic [DATA_WIDTH-1:0]     result;
    logic                      carry;
    logic                      zero;
    // flag control
    logic                      flagClear;
    logic                      carryLoad;
    logic                      zeroLoad;
    logic                      zeroFlag;

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////

    fibControl control (
        .clk       (clk),
        .arstN     (arstN),
        .reqValid  (reqValid),
        .reqCount  (reqCount),
        .reqReady  (reqReady),
        .termReady (termReady),
        .termValid (termValid),
        .termLast  (termLast),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .writeAddr (writeAddr),
        .writeEn   (writeEn),
        .writeSrc  (writeSrc),
        .seedData  (seedData),
        .aluOp     (aluOp),
        .flagClear (flagClear),
        .carryLoad (carryLoad),
        .zeroLoad  (zeroLoad),
        .zeroFlag  (zeroFlag)
    );

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////

    regFile registers (
        .clk       (clk),
        .arstN     (arstN),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .writeAddr (writeAddr),
        .writeEn   (writeEn),
        .writeSrc  (writeSrc),
        .seedData  (seedData),
        .result    (result),
        .operandA  (operandA),
        .operandB  (operandB)
    );

    alu adder (
        .aluOp    (aluOp),
        .operandA (operandA),
        .operandB (operandB),
        .result   (result),
        .carry    (carry),
        .zero     (zero)
    );

    // sticky carry goes straight out as overflow
    flagRegister flags (
        .clk         (clk),
        .arstN       (arstN),
        .flagClear   (flagClear),
        .carryLoad   (carryLoad),
        .zeroLoad    (zeroLoad),
        .carry       (carry),
        .zero        (zero),
        .carrySticky (termOverflow),
        .zeroFlag    (zeroFlag)
    );

    // newest term sits on read port A during EMIT
    assign termData = operandA;

endmodule

// ==== tb/fibEngineTb.sv ====
`timescale 1ns/1ps

module fibEngineTb;
    import fibPkg::*;

    localparam int NUM_REQUESTS = 40;
    localparam int MAX_TERMS    = 31;
    localparam int RESET_CYCLES = 16;
    // every term at worst six cycles, plus slack for gaps and reset
    localparam int TIMEOUT_NS   = NUM_REQUESTS * MAX_TERMS * 6 * 100 + 100000;

    logic                   clk;
    logic                   arstN;
    logic                   reqValid;
    logic [COUNT_WIDTH-1:0] reqCount;
    logic                   reqReady;
    logic                   termValid;
    logic [DATA_WIDTH-1:0]  termData;
    logic                   termLast;
    logic                   termOverflow;
    logic                   termReady;

    integer seed;
    int     valueErrors;
    int     protocolErrors;
    int     sent;
    int     gapCycles;
    // expected request in flight
    bit     busy;
    bit     reqAccepted;
    int     curCount;
    int     termIdx;
    // cycles until the next term must show
    bit     waiting;
    int     cyclesSince;
    int     waitCycles;
    // term outputs captured under back-pressure
    bit                    stalled;
    logic [DATA_WIDTH-1:0] heldData;
    logic                  heldLast;
    logic                  heldOvf;

    fibEngine dut_i (
        .clk          (clk),
        .arstN        (arstN),
        .reqValid     (reqValid),
        .reqCount     (reqCount),
        .reqReady     (reqReady),
        .termValid    (termValid),
        .termData     (termData),
        .termLast     (termLast),
        .termOverflow (termOverflow),
        .termReady    (termReady)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // true value, F(30) still fits in 32 bits
    function automatic logic [31:0] fibTrue(input int k);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] t;
        a = 32'd0;
        b = 32'd1;
        for (int i = 0; i < k; i++) begin
            t = a + b;
            a = b;
            b = t;
        end
        return a;
    endfunction

    // sticky, any term so far past 16 bits
    function automatic logic overflowSoFar(input int k);
        for (int j = 0; j <= k; j++) begin
            if (fibTrue(j) >= 32'd65536) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    //////////////////////////////////////////////////
    // per-cycle checks, stimulus, tracking
    //////////////////////////////////////////////////

    task automatic checkOutputs();
        logic        expectValid;
        logic [31:0] expTerm;
        expectValid = busy && (!waiting || cyclesSince == waitCycles);
        if (termValid !== expectValid) begin
            $display("[ERROR] %0d ns: termValid %b, expected %b (term %0d of %0d)",
                     $time, termValid, expectValid, termIdx, curCount);
            protocolErrors++;
        end
        // ready only while idle
        if (reqReady !== !busy) begin
            $display("[ERROR] %0d ns: reqReady %b, expected %b", $time, reqReady, !busy);
            protocolErrors++;
        end
        if (stalled && (termData !== heldData || termLast !== heldLast
                        || termOverflow !== heldOvf)) begin
            $display("[ERROR] %0d ns: term outputs changed while stalled", $time);
            protocolErrors++;
        end
        if (termValid === 1'b1 && busy) begin
            expTerm = fibTrue(termIdx);
            if (termData !== expTerm[DATA_WIDTH-1:0]) begin
                $display("[ERROR] %0d ns: F(%0d) data %h, expected %h",
                         $time, termIdx, termData, expTerm[DATA_WIDTH-1:0]);
                valueErrors++;
            end
            if (termLast !== (termIdx == curCount - 1)) begin
                $display("[ERROR] %0d ns: F(%0d) last %b, count %0d",
                         $time, termIdx, termLast, curCount);
                valueErrors++;
            end
            if (termOverflow !== overflowSoFar(termIdx)) begin
                $display("[ERROR] %0d ns: F(%0d) overflow %b, expected %b",
                         $time, termIdx, termOverflow, overflowSoFar(termIdx));
                valueErrors++;
            end
        end
        if (waiting) begin
            if (cyclesSince == waitCycles) begin
                waiting = 1'b0;
            end else begin
                cyclesSince++;
            end
        end
    endtask

    task automatic driveInputs();
        if (reqAccepted) begin
            reqValid    = 1'b0;
            reqAccepted = 1'b0;
        end
        if (!reqValid && !busy && sent < NUM_REQUESTS) begin
            if (gapCycles > 0) begin
                gapCycles--;
            end else begin
                reqValid = 1'b1;
                reqCount = COUNT_WIDTH'(1 + ($unsigned($random(seed)) % MAX_TERMS));
                sent++;
            end
        end
        // roughly 60 percent ready
        termReady = ($unsigned($random(seed)) % 100) < 60;
    endtask

    // inputs hold until the rising edge, so transfers are known here
    task automatic trackTransfers();
        if (reqValid && reqReady) begin
            busy        = 1'b1;
            reqAccepted = 1'b1;
            curCount    = int'(reqCount);
            termIdx     = 0;
            waiting     = 1'b1;
            cyclesSince = 0;
            // LOAD, SEED0, SEED1, DEC
            waitCycles  = 4;
            stalled     = 1'b0;
        end
        if (termValid === 1'b1 && busy) begin
            if (termReady) begin
                stalled = 1'b0;
                termIdx++;
                if (termIdx == curCount) begin
                    busy      = 1'b0;
                    gapCycles = $unsigned($random(seed)) % 4;
                end else begin
                    waiting     = 1'b1;
                    cyclesSince = 0;
                    // ADD, DEC
                    waitCycles  = 2;
                end
            end else begin
                stalled  = 1'b1;
                heldData = termData;
                heldLast = termLast;
                heldOvf  = termOverflow;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        seed           = 32'h394c1fe5;
        arstN          = 1'b0;
        reqValid       = 1'b0;
        reqCount       = '0;
        termReady      = 1'b0;
        valueErrors    = 0;
        protocolErrors = 0;
        sent           = 0;
        gapCycles      = 0;
        busy           = 1'b0;
        reqAccepted    = 1'b0;
        curCount       = 0;
        termIdx        = 0;
        waiting        = 1'b0;
        cyclesSince    = 0;
        waitCycles     = 0;
        stalled        = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        arstN = 1'b1;
        while (sent < NUM_REQUESTS || busy || reqValid) begin
            @(negedge clk);
            checkOutputs();
            driveInputs();
            trackTransfers();
        end
        // back to idle after the final transfer
        @(negedge clk);
        checkOutputs();
        $display("done: %0d requests, %0d value errors, %0d protocol errors",
                 sent, valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("run stalled: not finished after %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== fibEngine.f ====
rtl/fibPkg.sv
rtl/fibControl.sv
rtl/regFile.sv
rtl/alu.sv
rtl/flagRegister.sv
rtl/fibEngine.sv
tb/fibEngineTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the fibEngine testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module fibEngineTb \
    -f fibEngine.f --Mdir obj_dir -o fibEngineSim \
    && ./obj_dir/fibEngineSim > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat "$LOG"
grep -q "TEST FAILED" "$LOG" && exit 1
grep -q "TEST PASSED" "$LOG" || exit 1
exit 0
